/* hw/dram_bridge_pkg.sv */
// widths, depths and shared types for the manycore DRAM bridge, used by scoped reference
`default_nettype none

package dram_bridge_pkg;

  // DRAM channel address fields
  localparam int BA_W = 2;
  localparam int BG_W = 2;
  localparam int RO_W = 10;
  localparam int CO_W = 6;
  localparam int BO_W = 2;

  localparam int CH_ADDR_W = BA_W + BG_W + RO_W + CO_W + BO_W;

  // one DMA word per request
  localparam int DATA_W = 32;

  // core reset release delay after tag programming
  localparam int RESET_DEPTH = 3;

  // buffering on the request and read-return sides
  localparam int REQ_DEPTH = 2;
  localparam int RET_DEPTH = 4;

  // cache order is ba-bg-ro-co-bo, DRAM order is ro-bg-ba-co-bo
  typedef logic [CH_ADDR_W-1:0] ch_addr_t;

  typedef logic [DATA_W-1:0] data_t;

  // holds 0 up to RET_DEPTH
  typedef logic [$clog2(RET_DEPTH+1)-1:0] ret_cnt_t;

  typedef enum logic [0:0] {
    ISSUE_IDLE,
    ISSUE_WAIT
  } issue_state_e;

endpackage

`default_nettype wire

/* hw/mem_reset_seq.sv */
// holds the bridge in reset until tag programming is done, then releases it after a fixed delay
`default_nettype none
`timescale 1ns/1ns

module mem_reset_seq (
  input  logic   clk_i
  , input  logic rst_n_i
  , input  logic tag_done_i
  , output logic core_run_o
);

  logic [dram_bridge_pkg::RESET_DEPTH-1:0] run_chain_r;

  // any low input drops the whole chain at once
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || !tag_done_i) begin
      run_chain_r <= '0;
    end else begin
      run_chain_r <= {run_chain_r[dram_bridge_pkg::RESET_DEPTH-2:0], tag_done_i};
    end
  end

  // last stage is the run level
  assign core_run_o = run_chain_r[dram_bridge_pkg::RESET_DEPTH-1];

endmodule

`default_nettype wire

/* hw/dma_req_queue.sv */
// small circular queue that accepts vcache DMA requests and feeds the DRAM issue stage
`default_nettype none
`timescale 1ns/1ns

module dma_req_queue (
  input  logic                         clk_i
  , input  logic                       core_run_i
  , input  logic                       dma_pkt_v_i
  , input  logic                       dma_pkt_write_i
  , input  dram_bridge_pkg::ch_addr_t  dma_pkt_addr_i
  , input  dram_bridge_pkg::data_t     dma_pkt_data_i
  , output logic                       dma_pkt_yumi_o
  , output logic                       q_v_o
  , output logic                       q_write_o
  , output dram_bridge_pkg::ch_addr_t  q_addr_o
  , output dram_bridge_pkg::data_t     q_data_o
  , input  logic                       q_yumi_i
);

  logic [$clog2(dram_bridge_pkg::REQ_DEPTH)-1:0]   wr_ptr_r;
  logic [$clog2(dram_bridge_pkg::REQ_DEPTH)-1:0]   rd_ptr_r;
  logic [$clog2(dram_bridge_pkg::REQ_DEPTH+1)-1:0] count_r;

  logic                      write_mem [dram_bridge_pkg::REQ_DEPTH];
  dram_bridge_pkg::ch_addr_t addr_mem  [dram_bridge_pkg::REQ_DEPTH];
  dram_bridge_pkg::data_t    data_mem  [dram_bridge_pkg::REQ_DEPTH];

  logic full;
  logic push;
  logic pop;

  assign full = (count_r == dram_bridge_pkg::REQ_DEPTH);

  // take a request only while running and not full
  assign dma_pkt_yumi_o = dma_pkt_v_i & core_run_i & ~full;
  assign push = dma_pkt_yumi_o;

  assign q_v_o = (count_r != '0);
  assign pop = q_yumi_i & q_v_o;

  assign q_write_o = write_mem[rd_ptr_r];
  assign q_addr_o  = addr_mem[rd_ptr_r];
  assign q_data_o  = data_mem[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (!core_run_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == dram_bridge_pkg::REQ_DEPTH-1) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == dram_bridge_pkg::REQ_DEPTH-1) ? '0 : rd_ptr_r + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // entry storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      write_mem[wr_ptr_r] <= dma_pkt_write_i;
      addr_mem[wr_ptr_r]  <= dma_pkt_addr_i;
      data_mem[wr_ptr_r]  <= dma_pkt_data_i;
    end
  end

endmodule

`default_nettype wire

/* hw/dram_req_issue.sv */
// takes queued requests, hashes the address into DRAM order and holds them until the DRAM accepts
`default_nettype none
`timescale 1ns/1ns

module dram_req_issue (
  input  logic                         clk_i
  , input  logic                       core_run_i
  , input  logic                       q_v_i
  , input  logic                       q_write_i
  , input  dram_bridge_pkg::ch_addr_t  q_addr_i
  , input  dram_bridge_pkg::data_t     q_data_i
  , output logic                       q_yumi_o
  , input  logic                       ret_pop_i
  , output logic                       dram_req_v_o
  , output logic                       dram_write_not_read_o
  , output dram_bridge_pkg::ch_addr_t  dram_ch_addr_o
  , output dram_bridge_pkg::data_t     dram_data_o
  , input  logic                       dram_req_yumi_i
);

  dram_bridge_pkg::issue_state_e state_r;
  dram_bridge_pkg::ret_cnt_t     rd_outstanding_r;

  // cache-order fields of the queue head
  logic [dram_bridge_pkg::BA_W-1:0] ba;
  logic [dram_bridge_pkg::BG_W-1:0] bg;
  logic [dram_bridge_pkg::RO_W-1:0] ro;
  logic [dram_bridge_pkg::CO_W-1:0] co;
  logic [dram_bridge_pkg::BO_W-1:0] bo;

  logic credit_ok;
  logic take;
  logic take_read;
  logic dram_done;

  assign {ba, bg, ro, co, bo} = q_addr_i;

  // reads wait for a free slot in the return buffer
  assign credit_ok = (rd_outstanding_r != dram_bridge_pkg::ret_cnt_t'(dram_bridge_pkg::RET_DEPTH));

  assign take      = (state_r == dram_bridge_pkg::ISSUE_IDLE) & q_v_i & (q_write_i | credit_ok);
  assign take_read = take & ~q_write_i;
  assign q_yumi_o  = take;

  assign dram_req_v_o = (state_r == dram_bridge_pkg::ISSUE_WAIT);
  assign dram_done    = dram_req_v_o & dram_req_yumi_i;

  always_ff @(posedge clk_i) begin
    if (!core_run_i) begin
      state_r <= dram_bridge_pkg::ISSUE_IDLE;
    end else begin
      unique case (state_r)
        dram_bridge_pkg::ISSUE_IDLE: begin
          if (take) begin
            state_r <= dram_bridge_pkg::ISSUE_WAIT;
          end
        end
        dram_bridge_pkg::ISSUE_WAIT: begin
          if (dram_done) begin
            state_r <= dram_bridge_pkg::ISSUE_IDLE;
          end
        end
        default: state_r <= dram_bridge_pkg::ISSUE_IDLE;
      endcase
    end
  end

  // reads issued and not yet popped by the cache
  always_ff @(posedge clk_i) begin
    if (!core_run_i) begin
      rd_outstanding_r <= '0;
    end else begin
      case ({take_read, ret_pop_i})
        2'b10:   rd_outstanding_r <= rd_outstanding_r + 1'b1;
        2'b01:   rd_outstanding_r <= rd_outstanding_r - 1'b1;
        default: rd_outstanding_r <= rd_outstanding_r;
      endcase
    end
  end

  // request register, DRAM wants ro-bg-ba-co-bo
  always_ff @(posedge clk_i) begin
    if (take) begin
      dram_write_not_read_o <= q_write_i;
      dram_ch_addr_o        <= {ro, bg, ba, co, bo};
      dram_data_o           <= q_data_i;
    end
  end

endmodule

`default_nettype wire

/* hw/dram_read_return.sv */
// buffers DRAM read completions and hands them back to the cache in cache address order
`default_nettype none
`timescale 1ns/1ns

module dram_read_return (
  input  logic                         clk_i
  , input  logic                       core_run_i
  , input  logic                       dram_data_v_i
  , input  dram_bridge_pkg::data_t     dram_data_i
  , input  dram_bridge_pkg::ch_addr_t  dram_read_addr_i
  , output logic                       dma_data_v_o
  , output dram_bridge_pkg::data_t     dma_data_o
  , output dram_bridge_pkg::ch_addr_t  dma_data_addr_o
  , input  logic                       dma_data_yumi_i
  , output logic                       ret_pop_o
);

  logic [$clog2(dram_bridge_pkg::RET_DEPTH)-1:0] wr_ptr_r;
  logic [$clog2(dram_bridge_pkg::RET_DEPTH)-1:0] rd_ptr_r;
  dram_bridge_pkg::ret_cnt_t                     count_r;

  dram_bridge_pkg::data_t    data_mem [dram_bridge_pkg::RET_DEPTH];
  dram_bridge_pkg::ch_addr_t addr_mem [dram_bridge_pkg::RET_DEPTH];

  // DRAM-order fields of the completion address
  logic [dram_bridge_pkg::RO_W-1:0] ro;
  logic [dram_bridge_pkg::BG_W-1:0] bg;
  logic [dram_bridge_pkg::BA_W-1:0] ba;
  logic [dram_bridge_pkg::CO_W-1:0] co;
  logic [dram_bridge_pkg::BO_W-1:0] bo;

  logic push;
  logic pop;

  assign {ro, bg, ba, co, bo} = dram_read_addr_i;

  // no back-pressure toward DRAM, issue credits keep room free
  assign push = dram_data_v_i;

  assign dma_data_v_o    = (count_r != '0);
  assign dma_data_o      = data_mem[rd_ptr_r];
  assign dma_data_addr_o = addr_mem[rd_ptr_r];

  assign pop       = dma_data_yumi_i & dma_data_v_o;
  assign ret_pop_o = pop;

  always_ff @(posedge clk_i) begin
    if (!core_run_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == dram_bridge_pkg::RET_DEPTH-1) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == dram_bridge_pkg::RET_DEPTH-1) ? '0 : rd_ptr_r + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // stored back in ba-bg-ro-co-bo for the cache
  always_ff @(posedge clk_i) begin
    if (push) begin
      data_mem[wr_ptr_r] <= dram_data_i;
      addr_mem[wr_ptr_r] <= {ba, bg, ro, co, bo};
    end
  end

endmodule

`default_nettype wire

/* hw/manycore_dram_bridge.sv */
// top of the vcache DMA to DRAM channel bridge, instantiated by the harness or testbench
`default_nettype none
`timescale 1ns/1ns

module manycore_dram_bridge (
  input  logic                         clk_i
  , input  logic                       rst_n_i
  , input  logic                       tag_done_i
  , output logic                       ready_o

  // vcache DMA request side
  , input  logic                       dma_pkt_v_i
  , input  logic                       dma_pkt_write_i
  , input  dram_bridge_pkg::ch_addr_t  dma_pkt_addr_i
  , input  dram_bridge_pkg::data_t     dma_pkt_data_i
  , output logic                       dma_pkt_yumi_o

  // DRAM channel
  , output logic                       dram_req_v_o
  , output logic                       dram_write_not_read_o
  , output dram_bridge_pkg::ch_addr_t  dram_ch_addr_o
  , output dram_bridge_pkg::data_t     dram_data_o
  , input  logic                       dram_req_yumi_i
  , input  logic                       dram_data_v_i
  , input  dram_bridge_pkg::data_t     dram_data_i
  , input  dram_bridge_pkg::ch_addr_t  dram_read_addr_i

  // read data back to the vcache
  , output logic                       dma_data_v_o
  , output dram_bridge_pkg::data_t     dma_data_o
  , output dram_bridge_pkg::ch_addr_t  dma_data_addr_o
  , input  logic                       dma_data_yumi_i
);

  logic                      core_run;
  logic                      q_v;
  logic                      q_write;
  dram_bridge_pkg::ch_addr_t q_addr;
  dram_bridge_pkg::data_t    q_data;
  logic                      q_yumi;
  logic                      ret_pop;

  mem_reset_seq reset_seq (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.tag_done_i(tag_done_i)
    ,.core_run_o(core_run)
  );

  assign ready_o = core_run;

  dma_req_queue req_queue (
    .clk_i(clk_i)
    ,.core_run_i(core_run)
    ,.dma_pkt_v_i(dma_pkt_v_i)
    ,.dma_pkt_write_i(dma_pkt_write_i)
    ,.dma_pkt_addr_i(dma_pkt_addr_i)
    ,.dma_pkt_data_i(dma_pkt_data_i)
    ,.dma_pkt_yumi_o(dma_pkt_yumi_o)
    ,.q_v_o(q_v)
    ,.q_write_o(q_write)
    ,.q_addr_o(q_addr)
    ,.q_data_o(q_data)
    ,.q_yumi_i(q_yumi)
  );

  dram_req_issue req_issue (
    .clk_i(clk_i)
    ,.core_run_i(core_run)
    ,.q_v_i(q_v)
    ,.q_write_i(q_write)
    ,.q_addr_i(q_addr)
    ,.q_data_i(q_data)
    ,.q_yumi_o(q_yumi)
    ,.ret_pop_i(ret_pop)
    ,.dram_req_v_o(dram_req_v_o)
    ,.dram_write_not_read_o(dram_write_not_read_o)
    ,.dram_ch_addr_o(dram_ch_addr_o)
    ,.dram_data_o(dram_data_o)
    ,.dram_req_yumi_i(dram_req_yumi_i)
  );

  dram_read_return read_return (
    .clk_i(clk_i)
    ,.core_run_i(core_run)
    ,.dram_data_v_i(dram_data_v_i)
    ,.dram_data_i(dram_data_i)
    ,.dram_read_addr_i(dram_read_addr_i)
    ,.dma_data_v_o(dma_data_v_o)
    ,.dma_data_o(dma_data_o)
    ,.dma_data_addr_o(dma_data_addr_o)
    ,.dma_data_yumi_i(dma_data_yumi_i)
    ,.ret_pop_o(ret_pop)
  );

endmodule

`default_nettype wire

/* test/dram_bridge_model.svh */
// DRAM channel model and reference address hashing, included inside the bridge testbench module
`ifndef DRAM_BRIDGE_MODEL_SVH
`define DRAM_BRIDGE_MODEL_SVH

// column and byte bits sit in the same place in both orders
localparam int LO_W = dram_bridge_pkg::CO_W + dram_bridge_pkg::BO_W;

// written DRAM words by DRAM-order address
dram_bridge_pkg::ch_addr_t dram_keys [$];
dram_bridge_pkg::data_t    dram_vals [$];

// reads taken by the DRAM, answered in issue order
dram_bridge_pkg::data_t    pend_data [$];
dram_bridge_pkg::ch_addr_t pend_addr [$];
longint                    pend_due  [$];

// cache order ba-bg-ro-lo into DRAM order ro-bg-ba-lo
function automatic dram_bridge_pkg::ch_addr_t to_dram_order(
  input dram_bridge_pkg::ch_addr_t a
);
  logic [dram_bridge_pkg::BA_W-1:0] ba;
  logic [dram_bridge_pkg::BG_W-1:0] bg;
  logic [dram_bridge_pkg::RO_W-1:0] ro;
  logic [LO_W-1:0]                  lo;
  ba = a[dram_bridge_pkg::CH_ADDR_W-1 -: dram_bridge_pkg::BA_W];
  bg = a[dram_bridge_pkg::CH_ADDR_W-dram_bridge_pkg::BA_W-1 -: dram_bridge_pkg::BG_W];
  ro = a[LO_W +: dram_bridge_pkg::RO_W];
  lo = a[LO_W-1:0];
  return {ro, bg, ba, lo};
endfunction

// contents of never-written words, spread over the whole address
function automatic dram_bridge_pkg::data_t fill_word(input dram_bridge_pkg::ch_addr_t a);
  return dram_bridge_pkg::data_t'({a, a[9:0]}) ^ 32'h3c96_a5e1;
endfunction

function automatic dram_bridge_pkg::data_t dram_read(input dram_bridge_pkg::ch_addr_t a);
  foreach (dram_keys[i]) begin
    if (dram_keys[i] == a) begin
      return dram_vals[i];
    end
  end
  return fill_word(a);
endfunction

function automatic void dram_write(
  input dram_bridge_pkg::ch_addr_t a,
  input dram_bridge_pkg::data_t    d
);
  foreach (dram_keys[i]) begin
    if (dram_keys[i] == a) begin
      dram_vals[i] = d;
      return;
    end
  end
  dram_keys.push_back(a);
  dram_vals.push_back(d);
endfunction

`endif

/* test/tb_manycore_dram_bridge.sv */
// random traffic testbench for the manycore DRAM bridge, built from the project file list
`default_nettype none
`timescale 1ns/1ns

module tb_manycore_dram_bridge;

  localparam int     CLK_PERIOD   = 40;
  localparam int     NUM_TXN      = 400;
  localparam int     WORST_CYCLES = 150;
  localparam int     POOL_SIZE    = 8;
  localparam int     MAX_RD_DELAY = 8;
  localparam longint TIMEOUT_NS   = longint'(NUM_TXN * WORST_CYCLES + 200) * CLK_PERIOD;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      tag_done;
  logic                      ready;
  logic                      dma_pkt_v;
  logic                      dma_pkt_write;
  dram_bridge_pkg::ch_addr_t dma_pkt_addr;
  dram_bridge_pkg::data_t    dma_pkt_data;
  logic                      dma_pkt_yumi;
  logic                      dram_req_v;
  logic                      dram_write_not_read;
  dram_bridge_pkg::ch_addr_t dram_ch_addr;
  dram_bridge_pkg::data_t    dram_wdata;
  logic                      dram_req_yumi;
  logic                      dram_data_v;
  dram_bridge_pkg::data_t    dram_rdata;
  dram_bridge_pkg::ch_addr_t dram_read_addr;
  logic                      dma_data_v;
  dram_bridge_pkg::data_t    dma_data;
  dram_bridge_pkg::ch_addr_t dma_data_addr;
  logic                      dma_data_yumi;

  `include "dram_bridge_model.svh"

  dram_bridge_pkg::ch_addr_t pool [POOL_SIZE];
  logic                      exp_req_write [$];
  dram_bridge_pkg::ch_addr_t exp_req_addr  [$];
  dram_bridge_pkg::data_t    exp_req_data  [$];
  dram_bridge_pkg::data_t    exp_ret_data  [$];
  dram_bridge_pkg::ch_addr_t exp_ret_addr  [$];

  longint cyc;
  int     acc_cnt;
  int     dram_cnt;
  int     dram_reads;
  int     pops;
  int     yumi_stall;

  manycore_dram_bridge manycore_dram_bridge_i (
    .clk_i(clk)
    ,.rst_n_i(rst_n)
    ,.tag_done_i(tag_done)
    ,.ready_o(ready)
    ,.dma_pkt_v_i(dma_pkt_v)
    ,.dma_pkt_write_i(dma_pkt_write)
    ,.dma_pkt_addr_i(dma_pkt_addr)
    ,.dma_pkt_data_i(dma_pkt_data)
    ,.dma_pkt_yumi_o(dma_pkt_yumi)
    ,.dram_req_v_o(dram_req_v)
    ,.dram_write_not_read_o(dram_write_not_read)
    ,.dram_ch_addr_o(dram_ch_addr)
    ,.dram_data_o(dram_wdata)
    ,.dram_req_yumi_i(dram_req_yumi)
    ,.dram_data_v_i(dram_data_v)
    ,.dram_data_i(dram_rdata)
    ,.dram_read_addr_i(dram_read_addr)
    ,.dma_data_v_o(dma_data_v)
    ,.dma_data_o(dma_data)
    ,.dma_data_addr_o(dma_data_addr)
    ,.dma_data_yumi_i(dma_data_yumi)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      $display("Testbench failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // handshakes complete on the rising edge
  always @(posedge clk) begin : monitor
    dram_bridge_pkg::ch_addr_t req_addr;
    cyc = cyc + 1;
    if (!ready) begin
      check_equal({dma_pkt_yumi, dram_req_v, dma_data_v}, 0, "strobes high while not ready");
    end
    if (dma_pkt_v && dma_pkt_yumi) begin
      exp_req_write.push_back(dma_pkt_write);
      exp_req_addr.push_back(dma_pkt_addr);
      exp_req_data.push_back(dma_pkt_data);
      acc_cnt++;
    end
    if (dram_req_v && dram_req_yumi) begin
      check_equal(exp_req_write.size() != 0, 1, "DRAM request with no cache request pending");
      req_addr = exp_req_addr.pop_front();
      check_equal(dram_write_not_read, exp_req_write.pop_front(), "DRAM write flag");
      check_equal(dram_ch_addr, to_dram_order(req_addr), "DRAM channel address");
      check_equal(dram_wdata, exp_req_data.pop_front(), "DRAM request data");
      if (dram_write_not_read) begin
        dram_write(dram_ch_addr, dram_wdata);
      end else begin
        exp_ret_data.push_back(dram_read(dram_ch_addr));
        exp_ret_addr.push_back(req_addr);
        pend_data.push_back(dram_read(dram_ch_addr));
        pend_addr.push_back(dram_ch_addr);
        pend_due.push_back(cyc + 1 + ($urandom % MAX_RD_DELAY));
        dram_reads++;
      end
      dram_cnt++;
    end
    if (dma_data_v && dma_data_yumi) begin
      check_equal(exp_ret_data.size() != 0, 1, "read return with no read outstanding");
      check_equal(dma_data, exp_ret_data.pop_front(), "read data to cache");
      check_equal(dma_data_addr, exp_ret_addr.pop_front(), "read address to cache");
      pops++;
    end
    check_equal((dram_reads - pops) <= dram_bridge_pkg::RET_DEPTH, 1, "reads beyond credits");
  end

  always @(negedge clk) begin
    if (acc_cnt < NUM_TXN) begin
      dma_pkt_v     = ($urandom % 4) != 0;
      dma_pkt_write = $urandom % 2;
      dma_pkt_addr  = pool[$urandom % POOL_SIZE];
      dma_pkt_data  = $urandom;
    end else begin
      dma_pkt_v = 1'b0;
    end
    // long cache stalls drain the read credits
    if (yumi_stall > 0) begin
      yumi_stall--;
      dma_data_yumi = 1'b0;
    end else if ($urandom % 64 == 0) begin
      yumi_stall    = 30 + $urandom % 30;
      dma_data_yumi = 1'b0;
    end else begin
      dma_data_yumi = ($urandom % 4) != 0;
    end
    dram_req_yumi = ($urandom % 3) != 0;
    if (pend_due.size() != 0 && cyc >= pend_due[0]) begin
      dram_data_v    = 1'b1;
      dram_rdata     = pend_data.pop_front();
      dram_read_addr = pend_addr.pop_front();
      void'(pend_due.pop_front());
    end else begin
      dram_data_v = 1'b0;
    end
  end

  initial begin : main
    int tag_wait;
    rst_n          = 1'b0;
    tag_done       = 1'b0;
    dma_pkt_v      = 1'b0;
    dma_pkt_write  = 1'b0;
    dma_pkt_addr   = '0;
    dma_pkt_data   = '0;
    dram_req_yumi  = 1'b0;
    dram_data_v    = 1'b0;
    dram_rdata     = '0;
    dram_read_addr = '0;
    dma_data_yumi  = 1'b0;
    cyc            = 0;
    acc_cnt        = 0;
    dram_cnt       = 0;
    dram_reads     = 0;
    pops           = 0;
    yumi_stall     = 0;
    void'($urandom(32'h984d2bc1));
    for (int i = 0; i < POOL_SIZE; i++) begin
      pool[i] = dram_bridge_pkg::ch_addr_t'($urandom);
    end
    tag_wait = 1 + $urandom % 6;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    repeat (tag_wait) begin
      @(negedge clk);
      check_equal(ready, 0, "ready_o before tag_done");
    end
    tag_done = 1'b1;
    for (int k = 1; k <= dram_bridge_pkg::RESET_DEPTH; k++) begin
      @(negedge clk);
      check_equal(ready, k == dram_bridge_pkg::RESET_DEPTH, "ready_o release delay");
    end
    while (!(acc_cnt == NUM_TXN && dram_cnt == NUM_TXN && exp_ret_data.size() == 0)) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    $display("Testbench passed");
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: only %0d of %0d requests reached the DRAM", dram_cnt, NUM_TXN);
    $display("Testbench failed");
    $fatal(1, "simulation timed out");
  end

endmodule

`default_nettype wire

/* manycore_dram_bridge.f */
+incdir+test
hw/dram_bridge_pkg.sv
hw/mem_reset_seq.sv
hw/dma_req_queue.sv
hw/dram_req_issue.sv
hw/dram_read_return.sv
hw/manycore_dram_bridge.sv
test/tb_manycore_dram_bridge.sv
